//--- design/debug_mon_pkg.sv
// ------------------------------------------------------------------
// Shared widths, RISC-V system instruction encodings and the
// enumerations for instruction kind, debug cause and monitor state
// ------------------------------------------------------------------
`default_nettype none

package debug_mon_pkg;

  // PC, instruction and halt address width
  localparam int XLEN = 32;

  // ------------------------------------------------------------------
  // Instruction encodings
  // ------------------------------------------------------------------
  // c.ebreak arrives expanded to this same encoding, with the compressed flag set
  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;
  localparam logic [31:0] INSTR_WFI    = 32'h1050_0073;
  localparam logic [31:0] INSTR_DRET   = 32'h7B20_0073;

  // ------------------------------------------------------------------
  // Enumerations
  // ------------------------------------------------------------------
  // Kind of the instruction at decode
  typedef enum logic [2:0] {
    KIND_OTHER   = 3'd0,
    KIND_EBREAK  = 3'd1,
    KIND_CEBREAK = 3'd2,
    KIND_WFI     = 3'd3,
    KIND_DRET    = 3'd4
  } instr_kind_e;

  // Values follow the dcsr.cause field
  typedef enum logic [2:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_e;

  // Monitor state
  typedef enum logic [1:0] {
    ST_RUN   = 2'd0,
    ST_SLEEP = 2'd1,
    ST_DEBUG = 2'd2
  } mon_state_e;

endpackage : debug_mon_pkg

`default_nettype wire

//--- design/debug_cause_arb.sv
// ------------------------------------------------------------------
// Instruction classifier and fixed-priority debug cause selection,
// with the first-after-wake suppression flag
// ------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module debug_cause_arb
  import debug_mon_pkg::*;
(
  input  wire logic            cov_assert_if,
  input  wire logic            rst_i,
  input  wire logic            accept_i,
  input  wire logic            run_i,
  input  wire logic            woke_i,
  input  wire logic [XLEN-1:0] instr_data_i,
  input  wire logic [XLEN-1:0] instr_pc_i,
  input  wire logic            instr_compressed_i,
  input  wire logic            debug_req_i,
  input  wire logic            ebreakm_i,
  input  wire logic            step_i,
  input  wire logic            trigger_en_i,
  input  wire logic [XLEN-1:0] trigger_addr_i,
  output instr_kind_e          kind_o,
  output dbg_cause_e           cause_o
);

  logic is_ebreak;
  logic trigger_hit;
  logic first_after_wake_q;

  // ------------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------------
  assign is_ebreak   = (instr_data_i == INSTR_EBREAK);
  assign trigger_hit = trigger_en_i && (instr_pc_i == trigger_addr_i);

  always_comb begin
    if (is_ebreak) begin
      kind_o = instr_compressed_i ? KIND_CEBREAK : KIND_EBREAK;
    end else if (instr_data_i == INSTR_WFI) begin
      kind_o = KIND_WFI;
    end else if (instr_data_i == INSTR_DRET) begin
      kind_o = KIND_DRET;
    end else begin
      kind_o = KIND_OTHER;
    end
  end

  // ------------------------------------------------------------------
  // First instruction after an irq wake
  // ------------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      first_after_wake_q <= 1'b0;
    end else if (woke_i) begin
      first_after_wake_q <= 1'b1;
    end else if (accept_i) begin
      first_after_wake_q <= 1'b0;
    end
  end

  // Priority: trigger, ebreak with ebreakm, halt request, step
  always_comb begin
    cause_o = CAUSE_NONE;
    if (accept_i && run_i) begin
      if (trigger_hit && !first_after_wake_q) begin
        cause_o = CAUSE_TRIGGER;
      end else if (is_ebreak && ebreakm_i && !first_after_wake_q) begin
        cause_o = CAUSE_EBREAK;
      end else if (debug_req_i) begin
        cause_o = CAUSE_HALTREQ;
      end else if (step_i) begin
        cause_o = CAUSE_STEP;
      end
    end
  end

endmodule : debug_cause_arb

`default_nettype wire

//--- design/debug_ctrl_fsm.sv
// ------------------------------------------------------------------
// Run / sleep / debug state machine with handshake ready, retire,
// dpc capture strobe and PC redirect generation
// ------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module debug_ctrl_fsm
  import debug_mon_pkg::*;
(
  input  wire logic            cov_assert_if,
  input  wire logic            rst_i,
  input  wire logic            instr_valid_i,
  input  wire logic [XLEN-1:0] instr_pc_i,
  input  wire logic            instr_compressed_i,
  input  instr_kind_e          kind_i,
  input  dbg_cause_e           cause_i,
  input  wire logic            debug_req_i,
  input  wire logic            irq_pending_i,
  input  wire logic [XLEN-1:0] dpc_i,
  input  wire logic [XLEN-1:0] halt_addr_i,
  output logic                 instr_ready_o,
  output logic                 accept_o,
  output logic                 run_o,
  output logic                 woke_o,
  output logic                 capture_o,
  output dbg_cause_e           capture_cause_o,
  output logic [XLEN-1:0]      capture_pc_o,
  output logic                 retire_o,
  output logic                 sleep_o,
  output logic                 debug_mode_o,
  output logic                 redirect_valid_o,
  output logic [XLEN-1:0]      redirect_pc_o
);

  mon_state_e      state_q;
  mon_state_e      state_d;
  logic [XLEN-1:0] wfi_pc_q;
  logic [XLEN-1:0] next_pc;
  logic            redirect_set;
  logic            redirect_to_dpc;
  logic            redirect_dpc_q;

  assign instr_ready_o = (state_q != ST_SLEEP);
  assign accept_o      = instr_valid_i && instr_ready_o;
  assign run_o         = (state_q == ST_RUN);
  assign sleep_o       = (state_q == ST_SLEEP);
  assign debug_mode_o  = (state_q == ST_DEBUG);
  // Debug request outranks the interrupt while asleep
  assign woke_o        = sleep_o && irq_pending_i && !debug_req_i;
  assign next_pc       = instr_pc_i + (instr_compressed_i ? XLEN'(2) : XLEN'(4));

  // ------------------------------------------------------------------
  // Next state and strobes
  // ------------------------------------------------------------------
  always_comb begin
    state_d         = state_q;
    capture_o       = 1'b0;
    capture_cause_o = CAUSE_NONE;
    capture_pc_o    = instr_pc_i;
    retire_o        = 1'b0;
    redirect_set    = 1'b0;
    redirect_to_dpc = 1'b0;
    case (state_q)
      ST_RUN: begin
        if (accept_o && (cause_i != CAUSE_NONE)) begin
          state_d         = ST_DEBUG;
          capture_o       = 1'b1;
          capture_cause_o = cause_i;
          redirect_set    = 1'b1;
          // Stepped instruction completes, dpc points past it
          if (cause_i == CAUSE_STEP) begin
            capture_pc_o = next_pc;
            retire_o     = 1'b1;
          end
        end else if (accept_o) begin
          retire_o = 1'b1;
          if (kind_i == KIND_WFI) begin
            state_d = ST_SLEEP;
          end
        end
      end
      ST_SLEEP: begin
        if (debug_req_i) begin
          state_d         = ST_DEBUG;
          capture_o       = 1'b1;
          capture_cause_o = CAUSE_HALTREQ;
          capture_pc_o    = wfi_pc_q + XLEN'(4);
          redirect_set    = 1'b1;
        end else if (irq_pending_i) begin
          state_d = ST_RUN;
        end
      end
      ST_DEBUG: begin
        if (accept_o) begin
          if ((kind_i == KIND_EBREAK) || (kind_i == KIND_CEBREAK)) begin
            // Restart at the halt address, dpc and cause untouched
            redirect_set = 1'b1;
          end else if (kind_i == KIND_DRET) begin
            state_d         = ST_RUN;
            redirect_set    = 1'b1;
            redirect_to_dpc = 1'b1;
            retire_o        = 1'b1;
          end else begin
            retire_o = 1'b1;
          end
        end
      end
      default: state_d = ST_RUN;
    endcase
  end

  // ------------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      state_q          <= ST_RUN;
      redirect_valid_o <= 1'b0;
      redirect_dpc_q   <= 1'b0;
    end else begin
      state_q          <= state_d;
      redirect_valid_o <= redirect_set;
      redirect_dpc_q   <= redirect_to_dpc;
    end
  end

  // PC of the wfi that put the monitor to sleep
  always_ff @(posedge cov_assert_if) begin
    if (run_o && (state_d == ST_SLEEP)) begin
      wfi_pc_q <= instr_pc_i;
    end
  end

  assign redirect_pc_o = redirect_dpc_q ? dpc_i : halt_addr_i;

endmodule : debug_ctrl_fsm

`default_nettype wire

//--- design/debug_pc_capture.sv
// ------------------------------------------------------------------
// Debug PC, debug cause and aligned halt address registers
// ------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module debug_pc_capture
  import debug_mon_pkg::*;
(
  input  wire logic            cov_assert_if,
  input  wire logic            rst_i,
  input  wire logic            capture_i,
  input  dbg_cause_e           capture_cause_i,
  input  wire logic [XLEN-1:0] capture_pc_i,
  input  wire logic [XLEN-1:0] dm_halt_addr_i,
  output logic [XLEN-1:0]      dpc_o,
  output dbg_cause_e           cause_o,
  output logic [XLEN-1:0]      halt_addr_o
);

  logic [XLEN-1:0] dpc_q;
  dbg_cause_e      cause_q;
  logic [XLEN-1:0] halt_addr_q;
  logic [XLEN-1:0] halt_addr_aligned;

  // Halt address is word aligned
  assign halt_addr_aligned = {dm_halt_addr_i[XLEN-1:2], 2'b00};

  // ------------------------------------------------------------------
  // dpc and cause
  // ------------------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      dpc_q   <= '0;
      cause_q <= CAUSE_NONE;
    end else if (capture_i) begin
      dpc_q   <= capture_pc_i;
      cause_q <= capture_cause_i;
    end
  end

  // ------------------------------------------------------------------
  // Halt address
  // ------------------------------------------------------------------
  // Sampled on entry only, so a change on dm_halt_addr_i during a
  // debug session does not move the ebreak restart target
  always_ff @(posedge cov_assert_if) begin
    if (capture_i) begin
      halt_addr_q <= halt_addr_aligned;
    end
  end

  assign dpc_o       = dpc_q;
  assign cause_o     = cause_q;
  assign halt_addr_o = halt_addr_q;

endmodule : debug_pc_capture

`default_nettype wire

//--- design/perf_counters.sv
// ------------------------------------------------------------------
// mcycle and minstret counters with per-counter inhibit
// ------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module perf_counters #(
  parameter int CNT_W = 32
) (
  input  wire logic             cov_assert_if,
  input  wire logic             rst_i,
  input  wire logic             retire_i,
  input  wire logic             sleep_i,
  input  wire logic             mcycle_inhibit_i,
  input  wire logic             minstret_inhibit_i,
  output logic [CNT_W-1:0]      mcycle_o,
  output logic [CNT_W-1:0]      minstret_o
);

  logic [CNT_W-1:0] mcycle_q;
  logic [CNT_W-1:0] minstret_q;
  logic             mcycle_en;
  logic             minstret_en;

  // Clock does not advance mcycle while asleep
  assign mcycle_en   = !sleep_i && !mcycle_inhibit_i;
  assign minstret_en = retire_i && !minstret_inhibit_i;

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      mcycle_q <= '0;
    end else if (mcycle_en) begin
      mcycle_q <= mcycle_q + CNT_W'(1);
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      minstret_q <= '0;
    end else if (minstret_en) begin
      minstret_q <= minstret_q + CNT_W'(1);
    end
  end

  assign mcycle_o   = mcycle_q;
  assign minstret_o = minstret_q;

endmodule : perf_counters

`default_nettype wire

//--- design/debug_monitor_top.sv
// ------------------------------------------------------------------
// Debug-entry monitor top level: cause arbiter, control FSM,
// dpc capture and performance counters
// ------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module debug_monitor_top
  import debug_mon_pkg::*;
#(
  parameter int CNT_W = 64
) (
  input  wire logic            cov_assert_if,
  input  wire logic            rst_i,
  // Decode handshake
  input  wire logic            instr_valid_i,
  input  wire logic [XLEN-1:0] instr_data_i,
  input  wire logic [XLEN-1:0] instr_pc_i,
  input  wire logic            instr_compressed_i,
  output logic                 instr_ready_o,
  // Debug and trigger controls
  input  wire logic            debug_req_i,
  input  wire logic            ebreakm_i,
  input  wire logic            step_i,
  input  wire logic            trigger_en_i,
  input  wire logic [XLEN-1:0] trigger_addr_i,
  input  wire logic [XLEN-1:0] dm_halt_addr_i,
  input  wire logic            irq_pending_i,
  input  wire logic            mcycle_inhibit_i,
  input  wire logic            minstret_inhibit_i,
  // Status
  output logic                 debug_mode_o,
  output logic                 sleep_o,
  output logic [XLEN-1:0]      dpc_o,
  output dbg_cause_e           cause_o,
  output logic                 redirect_valid_o,
  output logic [XLEN-1:0]      redirect_pc_o,
  output logic [CNT_W-1:0]     mcycle_o,
  output logic [CNT_W-1:0]     minstret_o
);

  instr_kind_e     kind;
  dbg_cause_e      sel_cause;
  dbg_cause_e      capture_cause;
  logic [XLEN-1:0] capture_pc;
  logic [XLEN-1:0] halt_addr;
  logic            accept;
  logic            run;
  logic            woke;
  logic            capture;
  logic            retire;

  debug_cause_arb u_cause_arb (
    .cov_assert_if      (cov_assert_if),
    .rst_i              (rst_i),
    .accept_i           (accept),
    .run_i              (run),
    .woke_i             (woke),
    .instr_data_i       (instr_data_i),
    .instr_pc_i         (instr_pc_i),
    .instr_compressed_i (instr_compressed_i),
    .debug_req_i        (debug_req_i),
    .ebreakm_i          (ebreakm_i),
    .step_i             (step_i),
    .trigger_en_i       (trigger_en_i),
    .trigger_addr_i     (trigger_addr_i),
    .kind_o             (kind),
    .cause_o            (sel_cause)
  );

  debug_ctrl_fsm u_ctrl_fsm (
    .cov_assert_if      (cov_assert_if),
    .rst_i              (rst_i),
    .instr_valid_i      (instr_valid_i),
    .instr_pc_i         (instr_pc_i),
    .instr_compressed_i (instr_compressed_i),
    .kind_i             (kind),
    .cause_i            (sel_cause),
    .debug_req_i        (debug_req_i),
    .irq_pending_i      (irq_pending_i),
    .dpc_i              (dpc_o),
    .halt_addr_i        (halt_addr),
    .instr_ready_o      (instr_ready_o),
    .accept_o           (accept),
    .run_o              (run),
    .woke_o             (woke),
    .capture_o          (capture),
    .capture_cause_o    (capture_cause),
    .capture_pc_o       (capture_pc),
    .retire_o           (retire),
    .sleep_o            (sleep_o),
    .debug_mode_o       (debug_mode_o),
    .redirect_valid_o   (redirect_valid_o),
    .redirect_pc_o      (redirect_pc_o)
  );

  debug_pc_capture u_pc_capture (
    .cov_assert_if   (cov_assert_if),
    .rst_i           (rst_i),
    .capture_i       (capture),
    .capture_cause_i (capture_cause),
    .capture_pc_i    (capture_pc),
    .dm_halt_addr_i  (dm_halt_addr_i),
    .dpc_o           (dpc_o),
    .cause_o         (cause_o),
    .halt_addr_o     (halt_addr)
  );

  perf_counters #(
    .CNT_W (CNT_W)
  ) u_perf_counters (
    .cov_assert_if      (cov_assert_if),
    .rst_i              (rst_i),
    .retire_i           (retire),
    .sleep_i            (sleep_o),
    .mcycle_inhibit_i   (mcycle_inhibit_i),
    .minstret_inhibit_i (minstret_inhibit_i),
    .mcycle_o           (mcycle_o),
    .minstret_o         (minstret_o)
  );

endmodule : debug_monitor_top

`default_nettype wire

//--- verif/debug_monitor_sva.sv
// ----------------------------------------------------------------------
// Concurrent assertions on the run / sleep / debug state machine,
// bound into every debug_ctrl_fsm instance
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module debug_monitor_sva
  import debug_mon_pkg::*;
(
  input wire logic cov_assert_if,
  input wire logic rst_i,
  input mon_state_e state_i,
  input wire logic ready_i,
  input wire logic irq_pending_i,
  input wire logic accept_i,
  input instr_kind_e kind_i,
  input dbg_cause_e cause_i,
  input wire logic redirect_i
);

  // A wfi retired in run mode puts the handshake into back-pressure
  assert property (@(posedge cov_assert_if) disable iff (rst_i)
    ((state_i == ST_RUN) && accept_i && (kind_i == KIND_WFI) && (cause_i == CAUSE_NONE))
    |=> !ready_i)
    else $error("instr_ready_o still high after a wfi put the monitor to sleep");

  // Redirect is a single-cycle pulse
  assert property (@(posedge cov_assert_if) disable iff (rst_i)
    redirect_i |=> !redirect_i)
    else $error("redirect_valid_o high for more than one cycle");

  // Only dret leaves debug mode, an interrupt does not
  assert property (@(posedge cov_assert_if) disable iff (rst_i)
    ((state_i == ST_DEBUG) && irq_pending_i && !(accept_i && (kind_i == KIND_DRET)))
    |=> (state_i == ST_DEBUG))
    else $error("irq_pending_i moved the monitor out of ST_DEBUG");

endmodule : debug_monitor_sva

bind debug_ctrl_fsm debug_monitor_sva u_sva (
  .cov_assert_if (cov_assert_if),
  .rst_i         (rst_i),
  .state_i       (state_q),
  .ready_i       (instr_ready_o),
  .irq_pending_i (irq_pending_i),
  .accept_i      (accept_o),
  .kind_i        (kind_i),
  .cause_i       (cause_i),
  .redirect_i    (redirect_valid_o)
);

`default_nettype wire

//--- verif/debug_monitor_tb.sv
// ----------------------------------------------------------------------
// Testbench for the debug-entry monitor: clock, reset, stimulus table,
// counter stretches, watchdog and final report
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module debug_monitor_tb
  import debug_mon_pkg::*;
();

  localparam int          CNT_W       = 64;
  localparam int          STRETCH_N   = 4;
  localparam logic [31:0] NOP         = 32'h0000_0013;
  localparam logic [31:0] HALT_ADDR   = 32'h0000_0803;
  // Halt address with the two low bits cleared
  localparam logic [31:0] HALT_TARGET = 32'h0000_0800;
  // Edges without an mcycle count when a wfi is woken by irq on the next row
  localparam int          SLEEP_EDGES = 2;

  // Expected redirect after acceptance
  localparam logic [1:0] R_NONE = 2'd0;
  localparam logic [1:0] R_HALT = 2'd1;
  localparam logic [1:0] R_DPC  = 2'd2;
  // Redirect to the halt address before acceptance (wake from sleep)
  localparam logic [1:0] R_WAKE = 2'd3;

  // flags is {compressed, debug_req, step, ebreakm, trigger_en, irq}
  // exp_state is {debug_mode, sleep}
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [5:0]  flags;
    logic [31:0] taddr;
    logic [1:0]  exp_state;
    dbg_cause_e  exp_cause;
    logic [31:0] exp_dpc;
    logic [1:0]  redir;
  } row_t;

  logic             cov_assert_if;
  logic             rst_i;
  logic             instr_valid_i;
  logic [31:0]      instr_data_i;
  logic [31:0]      instr_pc_i;
  logic             instr_compressed_i;
  logic             instr_ready_o;
  logic             debug_req_i;
  logic             ebreakm_i;
  logic             step_i;
  logic             trigger_en_i;
  logic [31:0]      trigger_addr_i;
  logic [31:0]      dm_halt_addr_i;
  logic             irq_pending_i;
  logic             mcycle_inhibit_i;
  logic             minstret_inhibit_i;
  logic             debug_mode_o;
  logic             sleep_o;
  logic [31:0]      dpc_o;
  dbg_cause_e       cause_o;
  logic             redirect_valid_o;
  logic [31:0]      redirect_pc_o;
  logic [CNT_W-1:0] mcycle_o;
  logic [CNT_W-1:0] minstret_o;

  row_t        rows[$];
  integer      seed;
  int          check_cnt = 0;
  int          err_cnt = 0;
  int unsigned edge_cnt = 0;
  bit          table_built = 1'b0;
  dbg_cause_e  last_cause = CAUSE_NONE;
  logic [31:0] last_dpc = 32'h0;

  debug_monitor_top #(
    .CNT_W (CNT_W)
  ) debug_monitor_top_inst (
    .cov_assert_if      (cov_assert_if),
    .rst_i              (rst_i),
    .instr_valid_i      (instr_valid_i),
    .instr_data_i       (instr_data_i),
    .instr_pc_i         (instr_pc_i),
    .instr_compressed_i (instr_compressed_i),
    .instr_ready_o      (instr_ready_o),
    .debug_req_i        (debug_req_i),
    .ebreakm_i          (ebreakm_i),
    .step_i             (step_i),
    .trigger_en_i       (trigger_en_i),
    .trigger_addr_i     (trigger_addr_i),
    .dm_halt_addr_i     (dm_halt_addr_i),
    .irq_pending_i      (irq_pending_i),
    .mcycle_inhibit_i   (mcycle_inhibit_i),
    .minstret_inhibit_i (minstret_inhibit_i),
    .debug_mode_o       (debug_mode_o),
    .sleep_o            (sleep_o),
    .dpc_o              (dpc_o),
    .cause_o            (cause_o),
    .redirect_valid_o   (redirect_valid_o),
    .redirect_pc_o      (redirect_pc_o),
    .mcycle_o           (mcycle_o),
    .minstret_o         (minstret_o)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #50 cov_assert_if = ~cov_assert_if;
  end

  always @(posedge cov_assert_if) begin
    edge_cnt <= edge_cnt + 1;
  end

  // ----------------------------------------------------------------------
  // Table helpers
  // ----------------------------------------------------------------------
  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("[FAIL] %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic add_row(input logic [31:0] instr, input logic [31:0] pc,
                         input logic [5:0] flags, input logic [31:0] taddr,
                         input logic [1:0] exp_state, input dbg_cause_e exp_cause,
                         input logic [31:0] exp_dpc, input logic [1:0] redir);
    row_t r;
    r = '{instr, pc, flags, taddr, exp_state, exp_cause, exp_dpc, redir};
    rows.push_back(r);
    last_cause = exp_cause;
    last_dpc   = exp_dpc;
  endtask

  // Plain instruction at a random PC in run mode, status unchanged
  function automatic row_t make_filler();
    row_t r;
    r = '{NOP, 32'h0, 6'b000000, 32'h0, 2'b00, last_cause, last_dpc, R_NONE};
    r.pc = $random(seed);
    return r;
  endfunction

  task automatic add_filler();
    rows.push_back(make_filler());
  endtask

  task automatic build_table();
    add_filler();
    // Priority: trigger over ebreak over halt request
    add_row(INSTR_EBREAK, 32'h100, 6'b010110, 32'h100, 2'b10, CAUSE_TRIGGER, 32'h100, R_HALT);
    add_row(INSTR_DRET,   32'h804, 6'b000000, 32'h0,   2'b00, CAUSE_TRIGGER, 32'h100, R_DPC);
    add_row(INSTR_EBREAK, 32'h110, 6'b010100, 32'h0,   2'b10, CAUSE_EBREAK,  32'h110, R_HALT);
    add_row(INSTR_DRET,   32'h804, 6'b000000, 32'h0,   2'b00, CAUSE_EBREAK,  32'h110, R_DPC);
    // c.ebreak alone
    add_row(INSTR_EBREAK, 32'h120, 6'b100100, 32'h0,   2'b10, CAUSE_EBREAK,  32'h120, R_HALT);
    add_row(INSTR_DRET,   32'h804, 6'b000000, 32'h0,   2'b00, CAUSE_EBREAK,  32'h120, R_DPC);
    add_row(NOP,          32'h130, 6'b011000, 32'h0,   2'b10, CAUSE_HALTREQ, 32'h130, R_HALT);
    add_row(INSTR_DRET,   32'h804, 6'b000000, 32'h0,   2'b00, CAUSE_HALTREQ, 32'h130, R_DPC);
    // Single step, dpc past the instruction
    add_row(NOP,          32'h140, 6'b001000, 32'h0,   2'b10, CAUSE_STEP,    32'h144, R_HALT);
    add_row(INSTR_DRET,   32'h804, 6'b000000, 32'h0,   2'b00, CAUSE_STEP,    32'h144, R_DPC);
    add_row(NOP,          32'h150, 6'b101000, 32'h0,   2'b10, CAUSE_STEP,    32'h152, R_HALT);
    add_row(INSTR_DRET,   32'h804, 6'b000000, 32'h0,   2'b00, CAUSE_STEP,    32'h152, R_DPC);
    add_row(INSTR_WFI,    32'h160, 6'b001000, 32'h0,   2'b10, CAUSE_STEP,    32'h164, R_HALT);
    add_row(INSTR_DRET,   32'h804, 6'b000000, 32'h0,   2'b00, CAUSE_STEP,    32'h164, R_DPC);
    // ebreak without ebreakm is an ordinary instruction
    add_row(INSTR_EBREAK, 32'h170, 6'b000000, 32'h0,   2'b00, CAUSE_STEP,    32'h164, R_NONE);
    add_filler();
    // Sleep, irq wake, trigger ignored once then taken
    add_row(INSTR_WFI,    32'h180, 6'b000000, 32'h0,   2'b01, CAUSE_STEP,    32'h164, R_NONE);
    add_row(NOP,          32'h190, 6'b000011, 32'h190, 2'b00, CAUSE_STEP,    32'h164, R_NONE);
    add_row(NOP,          32'h1a0, 6'b000010, 32'h1a0, 2'b10, CAUSE_TRIGGER, 32'h1a0, R_HALT);
    add_row(INSTR_DRET,   32'h804, 6'b000000, 32'h0,   2'b00, CAUSE_TRIGGER, 32'h1a0, R_DPC);
    // Halt request during sleep, debug wins over irq
    add_row(INSTR_WFI,    32'h1b0, 6'b000000, 32'h0,   2'b01, CAUSE_TRIGGER, 32'h1a0, R_NONE);
    add_row(NOP,          32'h1c0, 6'b010001, 32'h0,   2'b10, CAUSE_HALTREQ, 32'h1b4, R_WAKE);
    add_row(INSTR_WFI,    32'h808, 6'b000000, 32'h0,   2'b10, CAUSE_HALTREQ, 32'h1b4, R_NONE);
    add_row(INSTR_EBREAK, 32'h80c, 6'b000100, 32'h0,   2'b10, CAUSE_HALTREQ, 32'h1b4, R_HALT);
    add_row(INSTR_DRET,   32'h810, 6'b000000, 32'h0,   2'b00, CAUSE_HALTREQ, 32'h1b4, R_DPC);
    add_filler();
  endtask

  // ----------------------------------------------------------------------
  // Row application
  // ----------------------------------------------------------------------
  task automatic apply_row(input row_t r);
    bit saw_redir;
    saw_redir = 1'b0;
    @(posedge cov_assert_if);
    instr_valid_i  <= 1'b1;
    instr_data_i   <= r.instr;
    instr_pc_i     <= r.pc;
    trigger_addr_i <= r.taddr;
    {instr_compressed_i, debug_req_i, step_i, ebreakm_i, trigger_en_i, irq_pending_i} <= r.flags;
    // Hold the instruction while the monitor sleeps
    do begin
      @(negedge cov_assert_if);
      if (redirect_valid_o) begin
        saw_redir = 1'b1;
        check_val("redirect_pc_o", 64'(redirect_pc_o), 64'(HALT_TARGET));
      end
    end while (!instr_ready_o);
    @(posedge cov_assert_if);
    instr_valid_i <= 1'b0;
    @(negedge cov_assert_if);
    check_val("debug_mode_o", 64'(debug_mode_o), 64'(r.exp_state[1]));
    check_val("sleep_o", 64'(sleep_o), 64'(r.exp_state[0]));
    check_val("instr_ready_o", 64'(instr_ready_o), 64'(!r.exp_state[0]));
    check_val("cause_o", 64'(cause_o), 64'(r.exp_cause));
    check_val("dpc_o", 64'(dpc_o), 64'(r.exp_dpc));
    check_val("redirect_valid_o", 64'(redirect_valid_o), 64'(r.redir == R_HALT || r.redir == R_DPC));
    if (r.redir == R_HALT) begin
      check_val("redirect_pc_o", 64'(redirect_pc_o), 64'(HALT_TARGET));
    end else if (r.redir == R_DPC) begin
      check_val("redirect_pc_o", 64'(redirect_pc_o), 64'(r.exp_dpc));
    end else if (r.redir == R_WAKE) begin
      check_cnt++;
      assert (saw_redir) else begin
        err_cnt++;
        $display("No redirect seen when debug_req_i woke the monitor at %0t ns", $time);
      end
    end
  endtask

  // Filler rows in run mode, counters compared with edges and retired rows
  // Optionally led by a wfi and an irq wake, whose sleep edges mcycle skips
  task automatic run_stretch(input int n, input logic mcy_inh, input logic mret_inh,
                             input bit with_sleep);
    logic [CNT_W-1:0] mcy_start;
    logic [CNT_W-1:0] mret_start;
    int unsigned      edge_start;
    int unsigned      skipped;
    int               retired;
    row_t             r;
    int               i;
    @(posedge cov_assert_if);
    mcycle_inhibit_i   <= mcy_inh;
    minstret_inhibit_i <= mret_inh;
    @(negedge cov_assert_if);
    mcy_start  = mcycle_o;
    mret_start = minstret_o;
    edge_start = edge_cnt;
    skipped    = 0;
    retired    = n;
    if (with_sleep) begin
      r = make_filler();
      r.instr     = INSTR_WFI;
      r.exp_state = 2'b01;
      apply_row(r);
      r = make_filler();
      r.flags = 6'b000001;
      apply_row(r);
      skipped = SLEEP_EDGES;
      retired = n + 2;
    end
    for (i = 0; i < n; i++) begin
      apply_row(make_filler());
    end
    check_val("mcycle_o delta", 64'(mcycle_o - mcy_start),
              mcy_inh ? 64'd0 : 64'(edge_cnt - edge_start - skipped));
    check_val("minstret_o delta", 64'(minstret_o - mret_start),
              mret_inh ? 64'd0 : 64'(retired));
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_i              <= 1'b1;
    instr_valid_i      <= 1'b0;
    instr_data_i       <= NOP;
    instr_pc_i         <= 32'h0;
    instr_compressed_i <= 1'b0;
    debug_req_i        <= 1'b0;
    ebreakm_i          <= 1'b0;
    step_i             <= 1'b0;
    trigger_en_i       <= 1'b0;
    trigger_addr_i     <= 32'h0;
    dm_halt_addr_i     <= HALT_ADDR;
    irq_pending_i      <= 1'b0;
    mcycle_inhibit_i   <= 1'b0;
    minstret_inhibit_i <= 1'b0;
    seed = 32'hf2e7_964b;
    build_table();
    table_built = 1'b1;
    repeat (3) @(posedge cov_assert_if);
    rst_i <= 1'b0;
    @(negedge cov_assert_if);
    check_val("debug_mode_o", 64'(debug_mode_o), 64'd0);
    check_val("sleep_o", 64'(sleep_o), 64'd0);
    check_val("redirect_valid_o", 64'(redirect_valid_o), 64'd0);
    check_val("instr_ready_o", 64'(instr_ready_o), 64'd1);
    check_val("cause_o", 64'(cause_o), 64'(CAUSE_NONE));
    check_val("dpc_o", 64'(dpc_o), 64'd0);
    check_val("mcycle_o", 64'(mcycle_o), 64'd0);
    check_val("minstret_o", 64'(minstret_o), 64'd0);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    run_stretch(STRETCH_N, 1'b0, 1'b0, 1'b1);
    run_stretch(STRETCH_N, 1'b1, 1'b0, 1'b0);
    run_stretch(STRETCH_N, 1'b0, 1'b1, 1'b0);
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog, about 20 cycles per row
  initial begin
    wait (table_built);
    repeat ((rows.size() + 3 * STRETCH_N + 2) * 20 + 10) @(posedge cov_assert_if);
    $display("Timeout: the monitor stopped accepting instructions");
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    $display("TB FAILED");
    $finish;
  end

endmodule : debug_monitor_tb

`default_nettype wire

//--- tb.f
design/debug_mon_pkg.sv
design/debug_cause_arb.sv
design/debug_ctrl_fsm.sv
design/debug_pc_capture.sv
design/perf_counters.sv
design/debug_monitor_top.sv
verif/debug_monitor_sva.sv
verif/debug_monitor_tb.sv

//--- Makefile
# Verilator lint and simulation of the debug-entry monitor

TOP := debug_monitor_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TB FAILED" sim.log; then \
	  echo "Simulation reported a failure, see sim.log"; exit 1; \
	elif ! grep -q "TB PASSED" sim.log; then \
	  echo "Simulation ended without a result, see sim.log"; exit 1; \
	else \
	  echo "Simulation finished without failures"; \
	fi

clean:
	rm -rf obj_dir sim.log
